/* icache.f */
+incdir+src
src/icache_pkg.sv
src/sync_sram.sv
src/icache_tag_lookup.sv
src/icache_refill.sv
src/icache_ctrl.sv
src/icache.sv
testbench/icache_chk.sv
testbench/icache_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   -f icache.f \
   --top-module icache_tb \
   -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit "$status"
fi

# protocol assertions keep running so the testbench reports them
./obj_dir/Vicache_tb +verilator+error+limit+100
status=$?
if [ "$status" -ne 0 ]; then
   echo "simulation failed with status $status"
   exit "$status"
fi

exit 0

/* testbench/icache_tb.sv */
`timescale 1ns/100ps

`include "icache_macros.svh"

module icache_tb;
   import icache_pkg::*;

   localparam int CLK_PERIOD   = 100;
   localparam int DRIVE_DELAY  = 10;
   localparam int NUM_REQ      = 400;
   localparam int WORD_BYTES   = `ICACHE_WORD_W / 8;
   // cycles for one request in the worst case, random stalls included
   localparam int WORST_REFILL = 200;
   localparam int TIMEOUT_NS   = NUM_REQ * WORST_REFILL * CLK_PERIOD;

   logic     clk;
   logic     reset;
   logic     cpu_req_valid;
   cpu_req_t cpu_req;
   logic     cpu_req_ready;
   logic     cpu_rsp_valid;
   cpu_rsp_t cpu_rsp;
   logic     cpu_rsp_ready;
   logic     mem_req_valid;
   mem_req_t mem_req;
   logic     mem_req_ready;
   logic     mem_rsp_valid;
   word_t    mem_rsp_data;

   int cycle = 0;

   // memory side, words in flight and every accepted request address
   addr_t pend_addr [$];
   int    pend_due [$];
   addr_t req_log [$];

   // reference cache state
   tag_t model_tag [`ICACHE_SETS][`ICACHE_WAYS];
   logic model_valid [`ICACHE_SETS][`ICACHE_WAYS];
   logic model_lru [`ICACHE_SETS];

   icache dut_i (
      .clk           (clk),
      .reset         (reset),
      .cpu_req_valid (cpu_req_valid),
      .cpu_req       (cpu_req),
      .cpu_req_ready (cpu_req_ready),
      .cpu_rsp_valid (cpu_rsp_valid),
      .cpu_rsp       (cpu_rsp),
      .cpu_rsp_ready (cpu_rsp_ready),
      .mem_req_valid (mem_req_valid),
      .mem_req       (mem_req),
      .mem_req_ready (mem_req_ready),
      .mem_rsp_valid (mem_rsp_valid),
      .mem_rsp_data  (mem_rsp_data)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   // fixed scramble of the word address, byte bits dropped
   function automatic word_t scramble_word(input addr_t byte_addr);
      word_t word_addr;
      word_addr = byte_addr >> 2;
      return (word_addr * 32'h9E37_79B1) ^ {word_addr[15:0], word_addr[31:16]} ^ 32'h5A5A_C3C3;
   endfunction

   // predicts hit or miss, then applies the fill and the lru update
   function automatic logic model_access(input tag_t tag, input index_t index);
      logic hit;
      logic way;
      hit = 1'b0;
      way = model_lru[index];
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
         if (model_valid[index][w] && model_tag[index][w] == tag) begin
            hit = 1'b1;
            way = 1'(w);
         end
      end
      if (!hit) begin
         model_tag[index][way]   = tag;
         model_valid[index][way] = 1'b1;
      end
      model_lru[index] = !way;
      return hit;
   endfunction

   task automatic report_mismatch(input string msg);
      $display("FAIL %0d ns: %s", $time, msg);
      $display(">>> FAIL");
      $fatal(1, "wrong value from the icache");
   endtask

   task automatic drive_after_edge();
      @(posedge clk);
      #DRIVE_DELAY;
      cpu_rsp_ready = ($urandom_range(0, 2) != 0);
   endtask

   task automatic run_request(input addr_t addr, input int num);
      logic  expect_hit;
      logic  accepted;
      logic  done;
      int    gap;
      int    accept_edge;
      int    rsp_edge;
      int    mem_edge;
      word_t got;
      word_t expect_data;
      addr_t base;
      expect_hit  = model_access(addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W],
                                 addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W]);
      expect_data = scramble_word(addr);
      base        = {addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
      gap         = $urandom_range(0, 3);
      repeat (gap) begin
         @(negedge clk);
         assert (!cpu_rsp_valid) else report_mismatch("response with no open request");
         drive_after_edge();
      end
      cpu_req_valid = 1'b1;
      cpu_req.addr  = addr;
      accepted      = 1'b0;
      accept_edge   = 0;
      while (!accepted) begin
         @(negedge clk);
         assert (!cpu_rsp_valid) else report_mismatch("response with no open request");
         if (cpu_req_ready) begin
            accepted    = 1'b1;
            accept_edge = cycle + 1;
         end
         drive_after_edge();
      end
      cpu_req_valid = 1'b0;
      done     = 1'b0;
      rsp_edge = -1;
      mem_edge = -1;
      got      = '0;
      while (!done) begin
         @(negedge clk);
         if (mem_req_valid && mem_edge < 0) begin
            mem_edge = cycle;
         end
         if (cpu_rsp_valid && rsp_edge < 0) begin
            rsp_edge = cycle;
         end
         if (cpu_rsp_valid && cpu_rsp_ready) begin
            done = 1'b1;
            got  = cpu_rsp.data;
         end
         drive_after_edge();
      end
      assert (got == expect_data) else report_mismatch($sformatf(
         "request %0d at %h returned %h, expected %h", num, addr, got, expect_data));
      if (expect_hit) begin
         assert (rsp_edge == accept_edge + 2) else report_mismatch($sformatf(
            "hit %0d answered %0d edges after acceptance", num, rsp_edge - accept_edge));
         assert (mem_edge < 0 && req_log.size() == 0) else report_mismatch($sformatf(
            "hit %0d issued a memory request", num));
      end else begin
         assert (mem_edge == accept_edge + 2) else report_mismatch($sformatf(
            "miss %0d started its refill %0d edges after acceptance", num,
            mem_edge - accept_edge));
         assert (req_log.size() == `ICACHE_LINE_WORDS) else report_mismatch($sformatf(
            "miss %0d issued %0d memory requests", num, req_log.size()));
         for (int i = 0; i < `ICACHE_LINE_WORDS; i++) begin
            assert (req_log[i] == base + addr_t'(i * WORD_BYTES)) else report_mismatch(
               $sformatf("miss %0d word %0d requested %h", num, i, req_log[i]));
         end
      end
      req_log.delete();
   endtask

   // memory model, in order with a random delay per word
   initial begin
      mem_req_ready = 1'b0;
      mem_rsp_valid = 1'b0;
      mem_rsp_data  = '0;
      forever begin
         @(negedge clk);
         if (mem_req_valid && mem_req_ready) begin
            req_log.push_back(mem_req.addr);
            pend_addr.push_back(mem_req.addr);
            pend_due.push_back(cycle + 1 + int'($urandom_range(0, 3)));
         end
         if (mem_rsp_valid) begin
            void'(pend_addr.pop_front());
            void'(pend_due.pop_front());
         end
         @(posedge clk);
         #DRIVE_DELAY;
         mem_req_ready = ($urandom_range(0, 3) != 0);
         if (pend_addr.size() > 0 && pend_due[0] <= cycle) begin
            mem_rsp_valid = 1'b1;
            mem_rsp_data  = scramble_word(pend_addr[0]);
         end else begin
            mem_rsp_valid = 1'b0;
         end
      end
   end

   always @(negedge clk) begin
      assert (dut_i.chk_i.protocol_ok) else begin
         $display(">>> FAIL");
         $fatal(1, "a bound protocol assertion on the icache ports failed");
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display(">>> FAIL");
      $fatal(1, "watchdog timeout, the requests did not complete in time");
   end

   initial begin
      addr_t      addr;
      tag_t       tag;
      index_t     index;
      word_sel_t  word;
      logic [1:0] byte_lo;
      void'($urandom(42));
      reset         = 1'b1;
      cpu_req_valid = 1'b0;
      cpu_req       = '0;
      cpu_rsp_ready = 1'b0;
      for (int s = 0; s < `ICACHE_SETS; s++) begin
         model_lru[s] = 1'b0;
         for (int w = 0; w < `ICACHE_WAYS; w++) begin
            model_tag[s][w]   = '0;
            model_valid[s][w] = 1'b0;
         end
      end
      repeat (2) @(posedge clk);
      #DRIVE_DELAY;
      reset = 1'b0;
      @(negedge clk);
      assert (!cpu_rsp_valid && !mem_req_valid && cpu_req_ready) else
         report_mismatch("handshake outputs wrong after reset");
      drive_after_edge();
      // four tags over four sets, so two-way sets keep evicting
      for (int n = 0; n < NUM_REQ; n++) begin
         tag     = tag_t'($urandom_range(0, 3) * 32'h2A5B + 32'h107);
         index   = index_t'($urandom_range(0, 3) * 9 + 1);
         word    = word_sel_t'($urandom_range(0, 15));
         byte_lo = 2'($urandom_range(0, 3));
         addr    = {tag, index, word, byte_lo};
         run_request(addr, n);
      end
      assert (pend_addr.size() == 0) else
         report_mismatch("memory requests left over after the last response");
      $display(">>> PASS");
      $finish;
   end

endmodule

/* testbench/icache_chk.sv */
`timescale 1ns/100ps

module icache_chk (
   input logic                 clk,
   input logic                 reset,
   input logic                 cpu_req_ready,
   input logic                 cpu_rsp_valid,
   input icache_pkg::cpu_rsp_t cpu_rsp,
   input logic                 cpu_rsp_ready,
   input logic                 mem_req_valid,
   input icache_pkg::mem_req_t mem_req,
   input logic                 mem_req_ready
);

   // one sticky flag per assertion, summed up for the testbench
   logic rsp_hold_bad = 1'b0;
   logic mem_hold_bad = 1'b0;
   logic ready_bad    = 1'b0;
   logic protocol_ok;

   assign protocol_ok = !(rsp_hold_bad || mem_hold_bad || ready_bad);

   // response held until the cpu takes it
   rsp_hold: assert property (@(posedge clk) disable iff (reset)
      cpu_rsp_valid && !cpu_rsp_ready |=> cpu_rsp_valid && $stable(cpu_rsp))
   else begin
      rsp_hold_bad = 1'b1;
      $error("cpu response dropped or changed while cpu_rsp_ready was low");
   end

   // memory request payload held while stalled
   mem_hold: assert property (@(posedge clk) disable iff (reset)
      mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
   else begin
      mem_hold_bad = 1'b1;
      $error("memory request dropped or changed while mem_req_ready was low");
   end

   // only one request open at a time
   no_accept_during_rsp: assert property (@(posedge clk) disable iff (reset)
      cpu_rsp_valid |-> !cpu_req_ready)
   else begin
      ready_bad = 1'b1;
      $error("cpu_req_ready high while a response is pending");
   end

endmodule

bind icache icache_chk chk_i (
   .clk           (clk),
   .reset         (reset),
   .cpu_req_ready (cpu_req_ready),
   .cpu_rsp_valid (cpu_rsp_valid),
   .cpu_rsp       (cpu_rsp),
   .cpu_rsp_ready (cpu_rsp_ready),
   .mem_req_valid (mem_req_valid),
   .mem_req       (mem_req),
   .mem_req_ready (mem_req_ready)
);

/* src/icache.sv */
`timescale 1ns/100ps

module icache (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 cpu_req_valid,
   input  icache_pkg::cpu_req_t cpu_req,
   output logic                 cpu_req_ready,
   output logic                 cpu_rsp_valid,
   output icache_pkg::cpu_rsp_t cpu_rsp,
   input  logic                 cpu_rsp_ready,
   output logic                 mem_req_valid,
   output icache_pkg::mem_req_t mem_req,
   input  logic                 mem_req_ready,
   input  logic                 mem_rsp_valid,
   input  icache_pkg::word_t    mem_rsp_data
);
   import icache_pkg::*;

   index_t   rd_index;
   tag_t     req_tag;
   way_vec_t hit;
   logic     victim_way;
   line_t    way0_line;
   line_t    way1_line;
   logic     data_we0;
   logic     data_we1;
   line_t    fill_line;
   logic     fill_we;
   logic     fill_way;
   index_t   fill_index;
   tag_t     fill_tag;
   logic     lru_we;
   logic     lru_next;
   index_t   lru_index;
   logic     refill_start;
   addr_t    line_base;
   logic     refill_done;
   line_t    refill_line;

   icache_ctrl ctrl_i (
      .clk           (clk),
      .reset         (reset),
      .cpu_req_valid (cpu_req_valid),
      .cpu_req       (cpu_req),
      .cpu_req_ready (cpu_req_ready),
      .cpu_rsp_valid (cpu_rsp_valid),
      .cpu_rsp       (cpu_rsp),
      .cpu_rsp_ready (cpu_rsp_ready),
      .rd_index      (rd_index),
      .req_tag       (req_tag),
      .hit           (hit),
      .victim_way    (victim_way),
      .way0_line     (way0_line),
      .way1_line     (way1_line),
      .data_we0      (data_we0),
      .data_we1      (data_we1),
      .fill_line     (fill_line),
      .fill_we       (fill_we),
      .fill_way      (fill_way),
      .fill_index    (fill_index),
      .fill_tag      (fill_tag),
      .lru_we        (lru_we),
      .lru_next      (lru_next),
      .lru_index     (lru_index),
      .refill_start  (refill_start),
      .line_base     (line_base),
      .refill_done   (refill_done),
      .refill_line   (refill_line)
   );

   icache_tag_lookup lookup_i (
      .clk        (clk),
      .reset      (reset),
      .rd_index   (rd_index),
      .req_tag    (req_tag),
      .fill_we    (fill_we),
      .fill_way   (fill_way),
      .fill_index (fill_index),
      .fill_tag   (fill_tag),
      .lru_we     (lru_we),
      .lru_index  (lru_index),
      .lru_next   (lru_next),
      .hit        (hit),
      .victim_way (victim_way)
   );

   icache_refill refill_i (
      .clk           (clk),
      .reset         (reset),
      .start         (refill_start),
      .line_base     (line_base),
      .mem_req_ready (mem_req_ready),
      .mem_rsp_valid (mem_rsp_valid),
      .mem_rsp_data  (mem_rsp_data),
      .mem_req_valid (mem_req_valid),
      .mem_req       (mem_req),
      .done          (refill_done),
      .line          (refill_line)
   );

   // line storage, read at the same index as the tags
   sync_sram #(.entry_t(line_t)) data_way0_i (
      .clk   (clk),
      .raddr (rd_index),
      .rdata (way0_line),
      .we    (data_we0),
      .waddr (fill_index),
      .wdata (fill_line)
   );

   sync_sram #(.entry_t(line_t)) data_way1_i (
      .clk   (clk),
      .raddr (rd_index),
      .rdata (way1_line),
      .we    (data_we1),
      .waddr (fill_index),
      .wdata (fill_line)
   );

endmodule

/* src/icache_ctrl.sv */
`timescale 1ns/100ps

`include "icache_macros.svh"

module icache_ctrl (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 cpu_req_valid,
   input  icache_pkg::cpu_req_t cpu_req,
   output logic                 cpu_req_ready,
   output logic                 cpu_rsp_valid,
   output icache_pkg::cpu_rsp_t cpu_rsp,
   input  logic                 cpu_rsp_ready,
   output icache_pkg::index_t   rd_index,
   output icache_pkg::tag_t     req_tag,
   input  icache_pkg::way_vec_t hit,
   input  logic                 victim_way,
   input  icache_pkg::line_t    way0_line,
   input  icache_pkg::line_t    way1_line,
   output logic                 data_we0,
   output logic                 data_we1,
   output icache_pkg::line_t    fill_line,
   output logic                 fill_we,
   output logic                 fill_way,
   output icache_pkg::index_t   fill_index,
   output icache_pkg::tag_t     fill_tag,
   output logic                 lru_we,
   output logic                 lru_next,
   output icache_pkg::index_t   lru_index,
   output logic                 refill_start,
   output icache_pkg::addr_t    line_base,
   input  logic                 refill_done,
   input  icache_pkg::line_t    refill_line
);
   import icache_pkg::*;

   localparam int WORD_LSB = $clog2(`ICACHE_WORD_W / 8);

   typedef enum logic [1:0] {IDLE, LOOKUP, REFILL, RESPOND} state_t;

   state_t    state;
   logic      tags_ready;
   addr_t     req_addr;
   index_t    in_index;
   index_t    req_index;
   word_sel_t req_word;
   logic      decide;
   logic      lookup_hit;
   line_t     hit_line;

   // address fields of the incoming and the held request
   assign in_index  = cpu_req.addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
   assign req_index = req_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
   assign req_tag   = req_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
   assign req_word  = req_addr[`ICACHE_OFFSET_W-1:WORD_LSB];
   assign line_base = {req_addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};

   assign rd_index = (state == IDLE) ? in_index : req_index;

   // lookup result is registered, so decide in the second lookup cycle
   assign decide       = (state == LOOKUP) && tags_ready;
   assign lookup_hit   = |hit;
   assign refill_start = decide && !lookup_hit;
   assign hit_line     = hit[1] ? way1_line : way0_line;

   // victim stays put while the index is held through the refill
   assign fill_we    = (state == REFILL) && refill_done;
   assign fill_way   = victim_way;
   assign fill_index = req_index;
   assign fill_tag   = req_tag;
   assign fill_line  = refill_line;
   assign data_we0   = fill_we && !victim_way;
   assign data_we1   = fill_we && victim_way;

   // lru points away from the way just used
   assign lru_we    = (decide && lookup_hit) || fill_we;
   assign lru_next  = (state == REFILL) ? !victim_way : hit[0];
   assign lru_index = req_index;

   assign cpu_req_ready = (state == IDLE);
   assign cpu_rsp_valid = (state == RESPOND);

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= IDLE;
         tags_ready <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (cpu_req_valid) begin
                  state      <= LOOKUP;
                  tags_ready <= 1'b0;
               end
            end
            LOOKUP: begin
               tags_ready <= 1'b1;
               if (tags_ready) begin
                  state <= lookup_hit ? RESPOND : REFILL;
               end
            end
            REFILL: begin
               if (refill_done) begin
                  state <= RESPOND;
               end
            end
            RESPOND: begin
               if (cpu_rsp_ready) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // held request and response word
   always_ff @(posedge clk) begin
      if (cpu_req_ready && cpu_req_valid) begin
         req_addr <= cpu_req.addr;
      end
      if (decide && lookup_hit) begin
         cpu_rsp.data <= hit_line[req_word];
      end else if (fill_we) begin
         cpu_rsp.data <= refill_line[req_word];
      end
   end

endmodule

/* src/icache_refill.sv */
`timescale 1ns/100ps

`include "icache_macros.svh"

module icache_refill (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 start,
   input  icache_pkg::addr_t    line_base,
   input  logic                 mem_req_ready,
   input  logic                 mem_rsp_valid,
   input  icache_pkg::word_t    mem_rsp_data,
   output logic                 mem_req_valid,
   output icache_pkg::mem_req_t mem_req,
   output logic                 done,
   output icache_pkg::line_t    line
);
   import icache_pkg::*;

   localparam int WORD_BYTES = `ICACHE_WORD_W / 8;

   // words issued and words returned so far
   word_sel_t req_cnt;
   word_sel_t rsp_cnt;
   logic      rsp_busy;
   addr_t     req_addr;

   logic req_fire;
   logic rsp_take;

   assign req_fire     = mem_req_valid && mem_req_ready;
   assign rsp_take     = rsp_busy && mem_rsp_valid;
   assign mem_req.addr = req_addr;

   always_ff @(posedge clk) begin
      if (reset) begin
         mem_req_valid <= 1'b0;
         rsp_busy      <= 1'b0;
         req_cnt       <= '0;
         rsp_cnt       <= '0;
         done          <= 1'b0;
      end else begin
         done <= 1'b0;
         if (start) begin
            mem_req_valid <= 1'b1;
            rsp_busy      <= 1'b1;
            req_cnt       <= '0;
            rsp_cnt       <= '0;
         end else begin
            // request side may run ahead of responses
            if (req_fire) begin
               req_cnt <= req_cnt + 1'b1;
               if (req_cnt == '1) begin
                  mem_req_valid <= 1'b0;
               end
            end
            if (rsp_take) begin
               rsp_cnt <= rsp_cnt + 1'b1;
               if (rsp_cnt == '1) begin
                  rsp_busy <= 1'b0;
                  done     <= 1'b1;
               end
            end
         end
      end
   end

   // address steps one word per accepted request
   always_ff @(posedge clk) begin
      if (start) begin
         req_addr <= line_base;
      end else if (req_fire) begin
         req_addr <= req_addr + WORD_BYTES;
      end
   end

   // shift in from the top so word 0 ends up at the bottom
   always_ff @(posedge clk) begin
      if (rsp_take) begin
         line <= {mem_rsp_data, line[`ICACHE_LINE_WORDS-1:1]};
      end
   end

endmodule

/* src/icache_tag_lookup.sv */
`timescale 1ns/100ps

`include "icache_macros.svh"

module icache_tag_lookup (
   input  logic                 clk,
   input  logic                 reset,
   input  icache_pkg::index_t   rd_index,
   input  icache_pkg::tag_t     req_tag,
   input  logic                 fill_we,
   input  logic                 fill_way,
   input  icache_pkg::index_t   fill_index,
   input  icache_pkg::tag_t     fill_tag,
   input  logic                 lru_we,
   input  icache_pkg::index_t   lru_index,
   input  logic                 lru_next,
   output icache_pkg::way_vec_t hit,
   output logic                 victim_way
);
   import icache_pkg::*;

   tag_t                    way_tag [`ICACHE_WAYS];
   logic [`ICACHE_SETS-1:0] valid_q [`ICACHE_WAYS];
   logic [`ICACHE_SETS-1:0] lru_q;
   index_t                  rd_index_q;
   way_vec_t                hit_now;

   for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
      sync_sram #(.entry_t(tag_t)) tag_ram (
         .clk   (clk),
         .raddr (rd_index),
         .rdata (way_tag[w]),
         .we    (fill_we && (fill_way == 1'(w))),
         .waddr (fill_index),
         .wdata (fill_tag)
      );

      // compare against the tag held by the controller
      assign hit_now[w] = valid_q[w][rd_index_q] && (way_tag[w] == req_tag);
   end

   // same registered index as the tag arrays
   always_ff @(posedge clk) begin
      rd_index_q <= rd_index;
   end

   // valid and lru bits live in flops so reset can clear them
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q    <= '{default: '0};
         lru_q      <= '0;
         hit        <= '0;
         victim_way <= 1'b0;
      end else begin
         if (fill_we) begin
            valid_q[fill_way][fill_index] <= 1'b1;
         end
         if (lru_we) begin
            lru_q[lru_index] <= lru_next;
         end
         // Registering the compare keeps the tag match off the word select path.
         hit        <= hit_now;
         victim_way <= lru_q[rd_index_q];
      end
   end

endmodule

/* src/sync_sram.sv */
`timescale 1ns/100ps

`include "icache_macros.svh"

module sync_sram #(
   parameter type entry_t = logic
) (
   input  logic               clk,
   input  icache_pkg::index_t raddr,
   output entry_t             rdata,
   input  logic               we,
   input  icache_pkg::index_t waddr,
   input  entry_t             wdata
);
   import icache_pkg::*;

   entry_t mem [`ICACHE_SETS];
   index_t raddr_q;

   // read address is registered, data follows a cycle later
   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
      raddr_q <= raddr;
   end

   assign rdata = mem[raddr_q];

endmodule

/* src/icache_pkg.sv */
`include "icache_macros.svh"

package icache_pkg;

   typedef logic [`ICACHE_WORD_W-1:0] word_t;
   typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
   typedef logic [`ICACHE_TAG_W-1:0] tag_t;
   typedef logic [`ICACHE_INDEX_W-1:0] index_t;
   typedef logic [$clog2(`ICACHE_LINE_WORDS)-1:0] word_sel_t;

   // word 0 sits in the low bits
   typedef word_t [`ICACHE_LINE_WORDS-1:0] line_t;

   // one hit flag per way
   typedef logic [`ICACHE_WAYS-1:0] way_vec_t;

   typedef struct packed {
      addr_t addr;
   } cpu_req_t;

   typedef struct packed {
      word_t data;
   } cpu_rsp_t;

   // word aligned byte address
   typedef struct packed {
      addr_t addr;
   } mem_req_t;

endpackage

/* src/icache_macros.svh */
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// bus widths
`define ICACHE_WORD_W 32
`define ICACHE_ADDR_W 32

// 4 KB in total over two ways
`define ICACHE_LINE_WORDS 16
`define ICACHE_WAYS 2
`define ICACHE_SETS 32

// address fields from the top down are tag, index and byte offset in the line
`define ICACHE_INDEX_W 5
`define ICACHE_OFFSET_W 6
`define ICACHE_TAG_W 21

`endif
